// File: design/fixed_mul.sv
`timescale 1ns/1ps
`default_nettype none

module fixed_mul import rnn_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  mul_req_t req,
    output word_t    result,
    output logic     result_valid
);

    prod_t prod_q;
    logic  prod_valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            prod_valid   <= 1'b0;
            result_valid <= 1'b0;
        end
        else
        begin
            prod_valid   <= req.valid;
            result_valid <= prod_valid;
        end
    end

    // Stage 1 full signed product, stage 2 rescale
    always_ff @(posedge clk)
    begin
        prod_q <= prod_t'($signed(req.a)) * prod_t'($signed(req.b));
        result <= fx_scale(prod_q);
    end

endmodule

`default_nettype wire

// File: design/hidden_state_store.sv
`timescale 1ns/1ps
`default_nettype none

module hidden_state_store import rnn_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        emb_wr,
    input  emb_idx_t    emb_idx,
    input  word_t       emb_data,
    input  logic        neuron_wr,
    input  hidden_idx_t neuron_idx,
    input  word_t       neuron_data,
    input  logic        commit,
    input  hidden_idx_t src_idx,
    output word_t       src_word,
    output word_t       emb_word,
    input  hidden_idx_t hidden_sel,
    output word_t       hidden_value
);

    word_t emb_buf    [EMBEDDING_SIZE];
    word_t new_hidden [HIDDEN_SIZE];
    word_t old_hidden [HIDDEN_SIZE];   // Committed state of the previous step

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < EMBEDDING_SIZE; i++)
            begin
                emb_buf[i] <= '0;
            end
            for (int i = 0; i < HIDDEN_SIZE; i++)
            begin
                new_hidden[i] <= '0;
                old_hidden[i] <= '0;
            end
        end
        else
        begin
            if (emb_wr)
                emb_buf[emb_idx] <= emb_data;
            if (neuron_wr)
                new_hidden[neuron_idx] <= neuron_data;
            if (commit)
                old_hidden <= new_hidden;
        end
    end

    assign src_word     = old_hidden[src_idx];
    assign emb_word     = emb_buf[emb_idx];
    assign hidden_value = old_hidden[hidden_sel];

endmodule

`default_nettype wire

// File: design/mac_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module mac_accumulator import rnn_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  acc_beat_t beat,
    output word_t     sum,
    output logic      sum_valid
);

    word_t total;
    word_t total_next;

    assign total_next = total + beat.data;      // Wraps modulo 2^16

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            total     <= '0;
            sum_valid <= 1'b0;
        end
        else
        begin
            sum_valid <= beat.valid && beat.last;
            if (beat.valid)
                total <= beat.last ? '0 : total_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (beat.valid && beat.last)
            sum <= total_next;
    end

endmodule

`default_nettype wire

// File: design/rnn_cell_top.sv
`timescale 1ns/1ps
`default_nettype none

module rnn_cell_top import rnn_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  token_t      token,
    output logic        read_en,
    output addr_t       read_address,
    input  mem_rsp_t    read_rsp,
    output logic        busy,
    output logic        done,
    input  hidden_idx_t hidden_sel,
    output word_t       hidden_value
);

    mul_req_t    mul_req;
    word_t       mul_result;
    logic        mul_valid;
    acc_beat_t   acc_beat;
    word_t       acc_sum;
    logic        acc_sum_valid;
    logic        emb_wr;
    emb_idx_t    emb_idx;
    logic        neuron_wr;
    hidden_idx_t neuron_idx;
    hidden_idx_t src_idx;
    word_t       src_word;
    word_t       emb_word;
    logic        commit;

    rnn_sequencer u_rnn_sequencer (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .token         (token),
        .read_en       (read_en),
        .read_address  (read_address),
        .read_rsp      (read_rsp),
        .mul_req       (mul_req),
        .mul_result    (mul_result),
        .mul_valid     (mul_valid),
        .acc_beat      (acc_beat),
        .acc_sum_valid (acc_sum_valid),
        .emb_wr        (emb_wr),
        .emb_idx       (emb_idx),
        .neuron_wr     (neuron_wr),
        .neuron_idx    (neuron_idx),
        .src_idx       (src_idx),
        .src_word      (src_word),
        .emb_word      (emb_word),
        .commit        (commit),
        .busy          (busy),
        .done          (done)
    );

    fixed_mul u_fixed_mul (
        .clk          (clk),
        .reset        (reset),
        .req          (mul_req),
        .result       (mul_result),
        .result_valid (mul_valid)
    );

    mac_accumulator u_mac_accumulator (
        .clk       (clk),
        .reset     (reset),
        .beat      (acc_beat),
        .sum       (acc_sum),
        .sum_valid (acc_sum_valid)
    );

    hidden_state_store u_hidden_state_store (
        .clk          (clk),
        .reset        (reset),
        .emb_wr       (emb_wr),
        .emb_idx      (emb_idx),
        .emb_data     (read_rsp.data),          // Embedding words come straight from memory
        .neuron_wr    (neuron_wr),
        .neuron_idx   (neuron_idx),
        .neuron_data  (acc_sum),
        .commit       (commit),
        .src_idx      (src_idx),
        .src_word     (src_word),
        .emb_word     (emb_word),
        .hidden_sel   (hidden_sel),
        .hidden_value (hidden_value)
    );

endmodule

`default_nettype wire

// File: design/rnn_pkg.sv
`default_nettype none

package rnn_pkg;

    localparam int VOCAB_SIZE     = 8;
    localparam int EMBEDDING_SIZE = 4;
    localparam int HIDDEN_SIZE    = 4;
    localparam int DATA_W         = 16;
    localparam int FRAC_BITS      = 8;     // Q8.8
    localparam int ADDR_W         = 16;

    typedef logic signed [DATA_W-1:0]   word_t;
    typedef logic signed [2*DATA_W-1:0] prod_t;
    typedef logic [ADDR_W-1:0]          addr_t;
    typedef logic [$clog2(VOCAB_SIZE)-1:0]     token_t;
    typedef logic [$clog2(HIDDEN_SIZE)-1:0]    hidden_idx_t;
    typedef logic [$clog2(EMBEDDING_SIZE)-1:0] emb_idx_t;

    // Weight memory layout, tables packed back to back
    localparam addr_t EMB_BASE  = addr_t'(0);
    localparam addr_t IH_W_BASE = EMB_BASE + addr_t'(VOCAB_SIZE * EMBEDDING_SIZE);
    localparam addr_t HH_W_BASE = IH_W_BASE + addr_t'(HIDDEN_SIZE * EMBEDDING_SIZE);
    localparam addr_t IH_B_BASE = HH_W_BASE + addr_t'(HIDDEN_SIZE * HIDDEN_SIZE);
    localparam addr_t HH_B_BASE = IH_B_BASE + addr_t'(HIDDEN_SIZE);
    localparam int    MEM_WORDS = int'(HH_B_BASE) + HIDDEN_SIZE;

    localparam emb_idx_t    LAST_EMB    = emb_idx_t'(EMBEDDING_SIZE - 1);
    localparam hidden_idx_t LAST_HIDDEN = hidden_idx_t'(HIDDEN_SIZE - 1);

    typedef struct packed {
        word_t data;
        logic  valid;
    } mem_rsp_t;

    typedef struct packed {
        word_t a;
        word_t b;
        logic  valid;
    } mul_req_t;

    typedef struct packed {
        word_t data;
        logic  valid;
        logic  last;
    } acc_beat_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_EMB_REQ,
        ST_EMB_NEXT,
        ST_HH_REQ,
        ST_HH_MUL,
        ST_HH_BIAS_REQ,
        ST_IH_GAP,
        ST_IH_REQ,
        ST_IH_MUL,
        ST_IH_BIAS_REQ,
        ST_SUM_WAIT,
        ST_DONE
    } seq_state_t;

    // Full product back to Q8.8, arithmetic shift then truncate
    function automatic word_t fx_scale(prod_t p);
        return word_t'(p >>> FRAC_BITS);
    endfunction

endpackage

`default_nettype wire

// File: design/rnn_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module rnn_sequencer import rnn_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  token_t      token,
    output logic        read_en,
    output addr_t       read_address,
    input  mem_rsp_t    read_rsp,
    output mul_req_t    mul_req,
    input  word_t       mul_result,
    input  logic        mul_valid,
    output acc_beat_t   acc_beat,
    input  logic        acc_sum_valid,
    output logic        emb_wr,
    output emb_idx_t    emb_idx,
    output logic        neuron_wr,
    output hidden_idx_t neuron_idx,
    output hidden_idx_t src_idx,
    input  word_t       src_word,
    input  word_t       emb_word,
    output logic        commit,
    output logic        busy,
    output logic        done
);

    seq_state_t  state;
    token_t      token_q;
    emb_idx_t    elem;
    hidden_idx_t src;
    hidden_idx_t neuron;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state  <= ST_IDLE;
            elem   <= '0;
            src    <= '0;
            neuron <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                    if (start)
                    begin
                        token_q <= token;
                        elem    <= '0;
                        src     <= '0;
                        neuron  <= '0;
                        state   <= ST_EMB_REQ;
                    end
                ST_EMB_REQ:
                    if (read_rsp.valid)
                        state <= ST_EMB_NEXT;
                ST_EMB_NEXT:
                    if (elem == LAST_EMB)
                    begin
                        elem  <= '0;
                        state <= ST_HH_REQ;
                    end
                    else
                    begin
                        elem  <= elem + 1'b1;
                        state <= ST_EMB_REQ;
                    end
                ST_HH_REQ:
                    if (read_rsp.valid)
                        state <= ST_HH_MUL;
                ST_HH_MUL:
                    if (mul_valid)
                    begin
                        src   <= (src == LAST_HIDDEN) ? '0 : src + 1'b1;
                        state <= (src == LAST_HIDDEN) ? ST_HH_BIAS_REQ : ST_HH_REQ;
                    end
                ST_HH_BIAS_REQ:
                    if (read_rsp.valid)
                        state <= ST_IH_GAP;
                ST_IH_GAP:
                    state <= ST_IH_REQ;                 // Lets read_en drop between reads
                ST_IH_REQ:
                    if (read_rsp.valid)
                        state <= ST_IH_MUL;
                ST_IH_MUL:
                    if (mul_valid)
                    begin
                        elem  <= (elem == LAST_EMB) ? '0 : elem + 1'b1;
                        state <= (elem == LAST_EMB) ? ST_IH_BIAS_REQ : ST_IH_REQ;
                    end
                ST_IH_BIAS_REQ:
                    if (read_rsp.valid)
                        state <= ST_SUM_WAIT;
                ST_SUM_WAIT:
                    if (acc_sum_valid)
                    begin
                        neuron <= neuron + 1'b1;
                        state  <= (neuron == LAST_HIDDEN) ? ST_DONE : ST_HH_REQ;
                    end
                ST_DONE:
                    state <= ST_IDLE;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_comb
    begin
        read_en      = 1'b0;
        read_address = '0;
        mul_req      = '0;
        acc_beat     = '0;
        emb_wr       = 1'b0;
        neuron_wr    = 1'b0;
        commit       = 1'b0;
        done         = 1'b0;
        case (state)
            ST_EMB_REQ:
            begin
                read_en      = 1'b1;
                read_address = EMB_BASE + addr_t'(token_q) * addr_t'(EMBEDDING_SIZE)
                               + addr_t'(elem);
                emb_wr       = read_rsp.valid;
            end
            ST_HH_REQ:
            begin
                read_en      = 1'b1;
                read_address = HH_W_BASE + addr_t'(neuron) * addr_t'(HIDDEN_SIZE)
                               + addr_t'(src);
                mul_req      = '{a: read_rsp.data, b: src_word, valid: read_rsp.valid};
            end
            ST_HH_BIAS_REQ:
            begin
                read_en      = 1'b1;
                read_address = HH_B_BASE + addr_t'(neuron);
                acc_beat     = '{data: read_rsp.data, valid: read_rsp.valid, last: 1'b0};
            end
            ST_IH_REQ:
            begin
                read_en      = 1'b1;
                read_address = IH_W_BASE + addr_t'(neuron) * addr_t'(EMBEDDING_SIZE)
                               + addr_t'(elem);
                mul_req      = '{a: read_rsp.data, b: emb_word, valid: read_rsp.valid};
            end
            ST_IH_BIAS_REQ:
            begin
                read_en      = 1'b1;
                read_address = IH_B_BASE + addr_t'(neuron);
                acc_beat     = '{data: read_rsp.data, valid: read_rsp.valid, last: 1'b1};
            end
            ST_HH_MUL, ST_IH_MUL:
                acc_beat = '{data: mul_result, valid: mul_valid, last: 1'b0};
            ST_SUM_WAIT:
                neuron_wr = acc_sum_valid;
            ST_DONE:
            begin
                commit = 1'b1;
                done   = 1'b1;
            end
            default: ;
        endcase
    end

    assign busy       = (state != ST_IDLE) && (state != ST_DONE);
    assign emb_idx    = elem;
    assign src_idx    = src;
    assign neuron_idx = neuron;

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the RNN cell testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module rnn_cell_tb -f sources.f -o sim_rnn_cell > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/sim_rnn_cell > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
    exit 0
else
    exit 1
fi

// File: sim/rnn_cell_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rnn_cell_chk import rnn_pkg::*; (
    input wire logic     clk,
    input wire logic     reset,
    input wire logic     busy,
    input wire logic     done,
    input wire logic     read_en,
    input wire addr_t    read_address,
    input wire mem_rsp_t read_rsp
);

    int fail_count = 0;

    done_single_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else
        begin
            $error("done held high for more than one cycle");
            fail_count++;
        end

    busy_low_after_done: assert property (@(posedge clk) disable iff (reset)
        done |=> !busy)
        else
        begin
            $error("busy high in the cycle after done");
            fail_count++;
        end

    // Request must hold until the memory answers
    address_held: assert property (@(posedge clk) disable iff (reset)
        (read_en && !read_rsp.valid) |=> (read_en && $stable(read_address)))
        else
        begin
            $error("read request changed before valid");
            fail_count++;
        end

endmodule

bind rnn_cell_top rnn_cell_chk u_rnn_cell_chk (.*);

`default_nettype wire

// File: sim/rnn_cell_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rnn_cell_tb import rnn_pkg::*; ;

    localparam int IMAGE_WORDS  = MEM_WORDS + 3 + 3 * HIDDEN_SIZE;
    localparam int TOKEN_BASE   = MEM_WORDS;
    localparam int EXPECT_BASE  = MEM_WORDS + 3;
    localparam int STEP_TIMEOUT = 2000;
    localparam int ZERO_STATE   = -1;               // All-zero vector right after reset
    localparam int QUIET_CYCLES = 8;

    logic        clk;
    logic        por_reset;
    logic        tb_reset = 1'b0;
    logic        reset;
    logic        start = 1'b0;
    token_t      token = '0;
    logic        read_en;
    addr_t       read_address;
    mem_rsp_t    read_rsp = '0;
    logic        busy;
    logic        done;
    hidden_idx_t hidden_sel = '0;
    word_t       hidden_value;

    word_t image [IMAGE_WORDS];
    word_t committed [HIDDEN_SIZE];              // Model of the old hidden state
    int    lat_max = 1;
    int    lat_now = 1;
    int    wait_cnt = 0;
    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    done_seen = 0;

    assign reset = por_reset | tb_reset;

    tb_clock_gen u_tb_clock_gen (.clk(clk), .reset(por_reset));

    rnn_cell_top u_rnn_cell_top (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .token        (token),
        .read_en      (read_en),
        .read_address (read_address),
        .read_rsp     (read_rsp),
        .busy         (busy),
        .done         (done),
        .hidden_sel   (hidden_sel),
        .hidden_value (hidden_value)
    );

    // Weight memory with a fresh latency per request
    always @(posedge clk)
    begin
        if (reset)
        begin
            read_rsp <= '0;
            wait_cnt <= 0;
        end
        else if (read_rsp.valid)
        begin
            read_rsp.valid <= 1'b0;
            wait_cnt       <= 0;
            lat_now        <= (lat_max > 1) ? int'($urandom_range(lat_max, 1)) : 1;
        end
        else if (read_en)
        begin
            if (wait_cnt + 1 >= lat_now)
                read_rsp <= '{data: image[int'(read_address)], valid: 1'b1};
            else
                wait_cnt <= wait_cnt + 1;
        end
    end

    always @(negedge clk)
    begin
        if (done)
            done_seen <= done_seen + 1;
    end

    task automatic apply_reset();
        @(posedge clk);
        tb_reset <= 1'b1;
        repeat (4) @(posedge clk);
        tb_reset <= 1'b0;
        @(negedge clk);
        for (int i = 0; i < HIDDEN_SIZE; i++)
            committed[i] = '0;
    endtask

    // Runs one step; optionally fires a second start while busy
    task automatic run_step(input int step, input bit extra_start, input bit watch_old);
        int cyc;
        bit finished;
        cyc = 0;
        finished = 0;
        @(posedge clk);
        start <= 1'b1;
        token <= token_t'(image[TOKEN_BASE + step]);
        while (!finished && cyc < STEP_TIMEOUT)
        begin
            @(posedge clk);
            start      <= extra_start && (cyc == 3);
            hidden_sel <= hidden_idx_t'(cyc % HIDDEN_SIZE);
            @(negedge clk);
            if (cyc == 0)
            begin
                assert (busy)
                else
                begin
                    $display("** Error: busy = %h after start, expected 1", busy);
                    errors++;
                end
            end
            if (done)
                finished = 1;
            else if (watch_old)
            begin
                assert (hidden_value == committed[hidden_sel])
                else
                begin
                    $display("** Error: hidden_value[%0d] during step = %h, expected %h",
                             hidden_sel, hidden_value, committed[hidden_sel]);
                    errors++;
                end
            end
            cyc++;
        end
        if (!finished)
        begin
            $display("Timeout: no done pulse within %0d cycles", STEP_TIMEOUT);
            errors++;
        end
    endtask

    task automatic check_vector(input int step);
        word_t exp;
        for (int i = 0; i < HIDDEN_SIZE; i++)
        begin
            if (step == ZERO_STATE)
                exp = '0;
            else
                exp = image[EXPECT_BASE + step * HIDDEN_SIZE + i];
            @(posedge clk);
            hidden_sel <= hidden_idx_t'(i);
            @(negedge clk);
            assert (hidden_value == exp)
            else
            begin
                $display("** Error: hidden_value[%0d] = %h, expected %h", i, hidden_value, exp);
                errors++;
            end
            committed[i] = exp;
        end
    endtask

    // Extra start must leave nothing pending
    task automatic check_no_restart(input int dones_before);
        for (int c = 0; c < QUIET_CYCLES; c++)
        begin
            @(negedge clk);
            assert (!busy)
            else
            begin
                $display("** Error: busy = %h in cycle %0d after done, expected 0", busy, c + 1);
                errors++;
            end
        end
        assert (done_seen - dones_before == 1)
        else
        begin
            $display("** Error: done pulses = %h, expected %h", done_seen - dones_before, 1);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before)
            $display("PASS  %s", name);
        else
        begin
            tests_failed++;
            $display("FAIL  %s", name);
        end
    endtask

    initial
    begin
        int e0;
        int dones_before;
        void'($urandom(32'h7ef3_0fa9));
        $readmemh("sim/rnn_input.mem", image);
        apply_reset();

        e0 = errors;
        assert (!busy && !done)
        else
        begin
            $display("** Error: busy = %h, done = %h after reset, expected 0", busy, done);
            errors++;
        end
        check_vector(ZERO_STATE);
        report_test("reset state", e0);

        e0 = errors;
        run_step(0, 1'b0, 1'b0);
        check_vector(0);
        report_test("first step, latency 1", e0);

        e0 = errors;
        run_step(1, 1'b0, 1'b0);
        check_vector(1);
        run_step(2, 1'b0, 1'b0);
        check_vector(2);
        report_test("recurrence steps 2 and 3", e0);

        e0 = errors;
        apply_reset();
        lat_max = 6;                             // Latency 1 to 6 from here on
        run_step(0, 1'b0, 1'b0);
        check_vector(0);
        report_test("first step again, random latency", e0);

        e0 = errors;
        dones_before = done_seen;
        run_step(1, 1'b1, 1'b0);
        check_no_restart(dones_before);
        check_vector(1);
        report_test("start while busy ignored", e0);

        e0 = errors;
        run_step(2, 1'b0, 1'b1);
        check_vector(2);
        report_test("old state held during step", e0);

        errors += u_rnn_cell_top.u_rnn_cell_chk.fail_count;
        $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/rnn_input.mem
// Words 0-71: weight memory (embeddings, ih weights, hh weights, ih bias, hh bias)
// Then 3 tokens, then 3 expected hidden vectors, neuron 0 first
0000 0000 0000 0000 0100 0080 FF80 0040
0080 0100 0000 FF00 FFC0 0040 0100 0080
0010 0020 0030 0040 0050 0060 0070 0080
0090 00A0 00B0 00C0 00D0 00E0 00F0 0100
0100 0000 0080 0000 0000 0100 0000 0100
0080 0080 0080 0080 FF00 0000 0100 0040
0080 0000 0000 0000 0000 0100 0000 0080
0040 0040 0040 0040 0000 0000 FF80 0000
0010 0020 0000 FFF0 0008 0000 0010 0000
0001 0002 0003
00D8 00E0 00B0 FE80
0104 0040 008A FED8
00DA 008C 00F9 010B

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;                  // 4 ns period
    end

    initial
    begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: sources.f
design/rnn_pkg.sv
design/fixed_mul.sv
design/mac_accumulator.sv
design/hidden_state_store.sv
design/rnn_sequencer.sv
design/rnn_cell_top.sv
sim/tb_clock_gen.sv
sim/rnn_cell_chk.sv
sim/rnn_cell_tb.sv
